//--- tb/sl_support_stimulus.txt
# test retire ctrl trig_valid trig_sel tdata1 tdata2 dbus ibus flags dphase iphase dattr iattr
# retire: valid dbg dret trap exc cause[4:0] m u; ctrl: pc_set pc_mux[2:0] fetch_en dbg_req
# bus: req gnt gntpar rvalid we integrity; flags: req_after_exc first_dbg first_fetch rec_dbg hit
# phase: addr_cont resp_cont cnt[3:0]; attr: valid store integrity gntpar_err
1 000000000000 000010 0 0 0 0 000000 000000 00100 000000 000000 0000 0000
1 000000000000 000010 0 0 0 0 000000 000000 00000 000000 000000 0000 0000
1 000000000000 000001 0 0 0 0 000000 000000 00000 000000 000000 0000 0000
1 000000000000 000000 0 0 0 0 000000 000000 00010 000000 000000 0000 0000
1 100000000010 000000 0 0 0 0 000000 000000 00010 000000 000000 0000 0000
1 000000000000 000000 0 0 0 0 000000 000000 00010 000000 000000 0000 0000
1 100000000010 000000 0 0 0 0 000000 000000 00010 000000 000000 0000 0000
1 000000000000 000000 0 0 0 0 000000 000000 00000 000000 000000 0000 0000
1 100000000010 000001 0 0 0 0 000000 000000 00000 000000 000000 0000 0000
1 100000000010 000000 0 0 0 0 000000 000000 00010 000000 000000 0000 0000
1 000000000000 000000 0 0 0 0 000000 000000 00000 000000 000000 0000 0000
2 110000000010 000000 0 0 0 0 000000 000000 01000 000000 000000 0000 0000
2 110000000010 000000 0 0 0 0 000000 000000 00000 000000 000000 0000 0000
2 111000000010 000000 0 0 0 0 000000 000000 00000 000000 000000 0000 0000
2 000000000000 000000 0 0 0 0 000000 000000 00000 000000 000000 0000 0000
2 100000000010 000000 0 0 0 0 000000 000000 00000 000000 000000 0000 0000
2 110000000010 000000 0 0 0 0 000000 000000 01000 000000 000000 0000 0000
2 110000000010 000000 0 0 0 0 000000 000000 00000 000000 000000 0000 0000
2 111000000010 000000 0 0 0 0 000000 000000 00000 000000 000000 0000 0000
2 110000000010 000000 0 0 0 0 000000 000000 00000 000000 000000 0000 0000
2 100000000010 000000 0 0 0 0 000000 000000 00000 000000 000000 0000 0000
3 000000000000 101100 0 0 0 0 000000 000000 00000 000000 000000 0000 0000
3 000000000000 000000 0 0 0 0 110000 000000 00000 000000 000000 0000 0000
3 000000000000 000000 0 0 0 0 110010 000000 00000 010001 000000 0000 0000
3 000000000000 000000 0 0 0 0 000100 000000 10000 000010 000000 1000 0000
3 100000000010 000000 0 0 0 0 000100 000000 10000 000001 000000 1100 0000
3 000000000000 000000 0 0 0 0 000000 000000 00000 000000 000000 0000 0000
3 000000000000 110000 0 0 0 0 000000 000000 00000 000000 000000 0000 0000
3 000000000000 000000 0 0 0 0 101000 000000 00000 000000 000000 0000 0000
3 000000000000 000000 0 0 0 0 110000 000000 00000 100000 000000 0000 0000
3 100000000010 000000 0 0 0 0 000100 000000 00000 000001 000000 1000 0000
3 000000000000 000000 0 0 0 0 000000 000000 00000 000000 000000 0000 0000
4 100110001010 000000 1 0 50000200 00000004 000000 000000 00000 000000 000000 0000 0000
4 100110001010 000000 0 0 0 0 000000 000000 00001 000000 000000 0000 0000
4 110000000010 000000 0 0 0 0 000000 000000 01000 000000 000000 0000 0000
4 111000000010 000000 0 0 0 0 000000 000000 00000 000000 000000 0000 0000
4 000000000000 000000 0 0 0 0 000000 000000 00000 000000 000000 0000 0000
4 100110001110 000000 0 0 0 0 000000 000000 00000 000000 000000 0000 0000
4 100110001001 000000 0 0 0 0 000000 000000 00000 000000 000000 0000 0000
4 000000000000 000000 1 4 50000040 00000004 000000 000000 00000 000000 000000 0000 0000
4 100110001001 000000 0 0 0 0 000000 000000 00000 000000 000000 0000 0000
4 000000000000 000000 1 3 50000040 00000004 000000 000000 00000 000000 000000 0000 0000
4 100110001001 000000 0 0 0 0 000000 000000 00001 000000 000000 0000 0000
4 110000000010 000000 0 0 0 0 000000 000000 01000 000000 000000 0000 0000
4 111000000010 000000 0 0 0 0 000000 000000 00000 000000 000000 0000 0000
4 000000000000 000000 0 0 0 0 000000 000000 00000 000000 000000 0000 0000
4 000000000000 000000 1 3 60000040 00000004 000000 000000 00000 000000 000000 0000 0000
4 100110001001 000000 0 0 0 0 000000 000000 00000 000000 000000 0000 0000
5 000000000000 000000 0 0 0 0 101011 000000 00000 000000 000000 0000 0000
5 000000000000 000000 0 0 0 0 101011 110001 00000 100000 000000 0000 0000
5 000000000000 000000 0 0 0 0 110011 000000 00000 100000 010001 0000 0000
5 000000000000 000000 0 0 0 0 110000 000100 00000 010001 000001 0000 1010
5 000000000000 000000 0 0 0 0 110001 000000 00000 010010 000000 0000 0000
5 000000000000 000000 0 0 0 0 110110 000000 00000 000011 000000 1110 0000
5 000000000000 000000 0 0 0 0 000000 000000 00000 010011 000000 0000 0000
5 000000000000 000000 0 0 0 0 000100 000000 00000 000011 000000 1000 0000
5 000000000000 000000 0 0 0 0 000100 000000 00000 000010 000000 1010 0000
5 000000000000 000000 0 0 0 0 000000 000000 00000 010001 000000 0000 0000
5 000000000000 000000 0 0 0 0 000100 000000 00000 000001 000000 1100 0000
5 000000000000 000000 0 0 0 0 000000 000000 00000 000000 000000 0000 0000
6 000000000000 000000 0 0 0 0 100000 101000 00000 000000 000000 0000 0000
6 000000000000 000000 0 0 0 0 101000 100000 00000 100000 100000 0000 0000
6 000000000000 000000 0 0 0 0 110000 101000 00000 100000 100000 0000 0000
6 000000000000 000000 0 0 0 0 111010 110001 00000 010001 100000 0000 0000
6 000000000000 000000 0 0 0 0 110001 110000 00000 010010 010001 0000 0000
6 000000000000 000000 0 0 0 0 000100 000100 00000 000011 000010 1001 1011
6 000000000000 000000 0 0 0 0 000100 000000 00000 000010 010001 1101 0000
6 000000000000 000000 0 0 0 0 000100 000100 00000 000001 000001 1010 1000
6 000000000000 000000 0 0 0 0 000000 000000 00000 000000 000000 0000 0000

//--- src.f
hdl/sl_core_pkg.sv
hdl/sl_obi_pkg.sv
hdl/sl_obi_phase_monitor.sv
hdl/sl_req_attr_fifo.sv
hdl/sl_trigger_match.sv
hdl/sl_support_ctrl.sv
hdl/sl_support_top.sv
tb/sl_support_props.sv
tb/sl_support_tb.sv

//--- tb/sl_support_tb.sv
`default_nettype none

module sl_support_tb;

  import sl_core_pkg::*;
  import sl_obi_pkg::*;

  localparam int unsigned NUM_TRIGGERS = 4;
  localparam int unsigned FIFO_DEPTH   = 4;
  localparam int unsigned CNT_W        = 4;
  localparam int unsigned CLK_HALF     = 5;
  localparam int unsigned RESET_CYCLES = 4;
  // outputs settle well before the next rising edge
  localparam int unsigned SETTLE       = 2;

  // one line of the stimulus file, inputs then expected outputs
  typedef struct packed {
    logic [15:0] test;
    retire_t     retire;
    core_ctrl_t  ctrl;
    trig_wr_t    trig_wr;
    obi_bus_t    data_bus;
    obi_bus_t    instr_bus;
    core_flags_t exp_flags;
    obi_phase_t  exp_data_phase;
    obi_phase_t  exp_instr_phase;
    resp_attr_t  exp_data_attr;
    resp_attr_t  exp_instr_attr;
  } vector_t;

  logic        in_support_if;
  logic        arst_n_i;
  retire_t     retire;
  core_ctrl_t  ctrl;
  trig_wr_t    trig_wr;
  obi_bus_t    data_bus;
  obi_bus_t    instr_bus;
  core_flags_t flags;
  obi_phase_t  data_phase;
  obi_phase_t  instr_phase;
  resp_attr_t  data_attr;
  resp_attr_t  instr_attr;

  vector_t     vectors[$];
  int          errors;
  int          checks;
  bit          loaded;

  sl_support_top #(
    .NUM_TRIGGERS (NUM_TRIGGERS),
    .FIFO_DEPTH   (FIFO_DEPTH),
    .CNT_W        (CNT_W)
  ) dut0 (
    .in_support_if (in_support_if),
    .arst_n_i      (arst_n_i),
    .retire_i      (retire),
    .ctrl_i        (ctrl),
    .trig_wr_i     (trig_wr),
    .data_bus_i    (data_bus),
    .instr_bus_i   (instr_bus),
    .flags_o       (flags),
    .data_phase_o  (data_phase),
    .instr_phase_o (instr_phase),
    .data_attr_o   (data_attr),
    .instr_attr_o  (instr_attr)
  );

  initial begin : clock_gen
    in_support_if = 1'b0;
    forever begin
      #CLK_HALF in_support_if = ~in_support_if;
    end
  end

  // ------------------------------------------------------------
  // stimulus file parsing
  // ------------------------------------------------------------
  // lines starting with # are column notes
  task automatic load_vectors(output bit ok);
    int          fd;
    int          n;
    int          f_test;
    string       line;
    vector_t     v;
    logic [11:0] f_retire;
    logic [5:0]  f_ctrl;
    logic [0:0]  f_tv;
    logic [2:0]  f_tsel;
    logic [31:0] f_td1;
    logic [31:0] f_td2;
    logic [5:0]  f_dbus;
    logic [5:0]  f_ibus;
    logic [4:0]  f_flags;
    logic [5:0]  f_dph;
    logic [5:0]  f_iph;
    logic [3:0]  f_dattr;
    logic [3:0]  f_iattr;
    ok = 1'b1;
    fd = $fopen("tb/sl_support_stimulus.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file tb/sl_support_stimulus.txt");
      ok = 1'b0;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if ((n > 0) && (line.len() > 1) && (line.getc(0) != "#")) begin
          n = $sscanf(line, "%d %b %b %h %h %h %h %b %b %b %b %b %b %b",
                      f_test, f_retire, f_ctrl, f_tv, f_tsel, f_td1, f_td2,
                      f_dbus, f_ibus, f_flags, f_dph, f_iph, f_dattr, f_iattr);
          if (n != 14) begin
            $display("malformed line in the stimulus file: %s", line);
            ok = 1'b0;
          end else begin
            v.test            = 16'(f_test);
            v.retire          = f_retire;
            v.ctrl            = f_ctrl;
            v.trig_wr         = {f_tv, f_tsel, f_td1, f_td2};
            v.data_bus        = f_dbus;
            v.instr_bus       = f_ibus;
            v.exp_flags       = f_flags;
            v.exp_data_phase  = f_dph;
            v.exp_instr_phase = f_iph;
            v.exp_data_attr   = f_dattr;
            v.exp_instr_attr  = f_iattr;
            vectors.push_back(v);
          end
        end
      end
      $fclose(fd);
      if (vectors.size() == 0) begin
        $display("the stimulus file holds no vectors");
        ok = 1'b0;
      end
    end
  endtask

  task automatic apply_inputs(input vector_t v);
    retire    = v.retire;
    ctrl      = v.ctrl;
    trig_wr   = v.trig_wr;
    data_bus  = v.data_bus;
    instr_bus = v.instr_bus;
  endtask

  task automatic check_field(input string name, input logic [7:0] got,
                             input logic [7:0] exp, input int test, input int idx);
    checks++;
    assert (got === exp) else begin
      $display("Fail %0t: test %0d vector %0d %s is %b, expected %b",
               $time, test, idx, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_outputs(input vector_t v, input int idx);
    check_field("flags_o", 8'(flags), 8'(v.exp_flags), v.test, idx);
    check_field("data_phase_o", 8'(data_phase), 8'(v.exp_data_phase), v.test, idx);
    check_field("instr_phase_o", 8'(instr_phase), 8'(v.exp_instr_phase), v.test, idx);
    check_field("data_attr_o", 8'(data_attr), 8'(v.exp_data_attr), v.test, idx);
    check_field("instr_attr_o", 8'(instr_attr), 8'(v.exp_instr_attr), v.test, idx);
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin : run_vectors
    bit ok;
    int test_vectors;
    int test_err_base;
    int tests_done;
    retire        = '0;
    ctrl          = '0;
    trig_wr       = '0;
    data_bus      = '0;
    instr_bus     = '0;
    arst_n_i      = 1'b0;
    errors        = 0;
    checks        = 0;
    loaded        = 1'b0;
    test_vectors  = 0;
    test_err_base = 0;
    tests_done    = 0;
    load_vectors(ok);
    loaded = ok;
    if (!ok) begin
      $display("test failed");
      $finish;
    end else begin
      repeat (RESET_CYCLES) @(negedge in_support_if);
      arst_n_i = 1'b1;
      for (int i = 0; i < vectors.size(); i++) begin
        // drive on the falling edge, sample before the rising one
        @(negedge in_support_if);
        apply_inputs(vectors[i]);
        #SETTLE;
        check_outputs(vectors[i], i);
        test_vectors++;
        // last vector of a test number closes that test
        if ((i == vectors.size() - 1) || (vectors[i + 1].test != vectors[i].test)) begin
          $display("test %0d finished: %0d vectors, %0d mismatches",
                   vectors[i].test, test_vectors, errors - test_err_base);
          tests_done++;
          test_vectors  = 0;
          test_err_base = errors;
        end
      end
      $display("%0d tests, %0d vectors, %0d checks, %0d mismatches",
               tests_done, vectors.size(), checks, errors);
      if (errors == 0) begin
        $display("test passed");
      end else begin
        $display("test failed");
      end
      $finish;
    end
  end

  // run limit scales with the vector count
  initial begin : watchdog
    wait (loaded);
    #(2 * (vectors.size() + RESET_CYCLES + 1) * 2 * CLK_HALF);
    $display("simulation hung: the vectors did not finish in time");
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/sl_support_props.sv
`default_nettype none

module sl_support_props #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  wire logic                     in_support_if,
  input  wire logic                     arst_n_i,
  input  wire sl_core_pkg::retire_t     retire_i,
  input  wire sl_core_pkg::core_flags_t flags_i,
  input  wire sl_obi_pkg::obi_phase_t   data_phase_i,
  input  wire sl_obi_pkg::obi_phase_t   instr_phase_i
);

  // last retire was an exception that hit a trigger outside debug
  logic etrig_pending_q;

  always_ff @(posedge in_support_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      etrig_pending_q <= 1'b0;
    end else if (retire_i.valid) begin
      etrig_pending_q <= retire_i.exception && !retire_i.dbg_mode
                      && flags_i.exception_trigger_hit;
    end
  end

  // ------------------------------------------------------------
  // outstanding transfers stay within the buffer depth
  // ------------------------------------------------------------
  a_data_depth : assert property (@(posedge in_support_if) disable iff (!arst_n_i)
    data_phase_i.v_addr_ph_cnt <= FIFO_DEPTH)
    else $error("data bus outstanding count above FIFO depth");

  a_instr_depth : assert property (@(posedge in_support_if) disable iff (!arst_n_i)
    instr_phase_i.v_addr_ph_cnt <= FIFO_DEPTH)
    else $error("instr bus outstanding count above FIFO depth");

  // next retire after a trigger hit runs in debug mode
  a_etrig_debug : assert property (@(posedge in_support_if) disable iff (!arst_n_i)
    (etrig_pending_q && retire_i.valid) |-> retire_i.dbg_mode)
    else $error("retire after an exception trigger hit is not in debug mode");

  a_reset_flags : assert property (@(posedge in_support_if)
    !arst_n_i |-> (flags_i == '0))
    else $error("flags not zero while in reset");

endmodule

bind sl_support_top sl_support_props #(
  .FIFO_DEPTH (FIFO_DEPTH)
) u_props (
  .in_support_if (in_support_if),
  .arst_n_i      (arst_n_i),
  .retire_i      (retire_i),
  .flags_i       (flags_o),
  .data_phase_i  (data_phase_o),
  .instr_phase_i (instr_phase_o)
);

`default_nettype wire

//--- hdl/sl_support_top.sv
`default_nettype none

module sl_support_top #(
  parameter int unsigned NUM_TRIGGERS = 4,
  parameter int unsigned FIFO_DEPTH   = 4,
  parameter int unsigned CNT_W        = 4
) (
  input  wire logic                    in_support_if,
  input  wire logic                    arst_n_i,
  input  wire sl_core_pkg::retire_t    retire_i,
  input  wire sl_core_pkg::core_ctrl_t ctrl_i,
  input  wire sl_core_pkg::trig_wr_t   trig_wr_i,
  input  wire sl_obi_pkg::obi_bus_t    data_bus_i,
  input  wire sl_obi_pkg::obi_bus_t    instr_bus_i,
  output sl_core_pkg::core_flags_t     flags_o,
  output sl_obi_pkg::obi_phase_t       data_phase_o,
  output sl_obi_pkg::obi_phase_t       instr_phase_o,
  output sl_obi_pkg::resp_attr_t       data_attr_o,
  output sl_obi_pkg::resp_attr_t       instr_attr_o
);

  // exception trigger hit into the flag logic
  logic etrig_hit;

  // ------------------------------------------------------------
  // core side
  // ------------------------------------------------------------
  sl_trigger_match #(
    .NUM_TRIGGERS (NUM_TRIGGERS)
  ) u_trigger_match (
    .in_support_if (in_support_if),
    .arst_n_i      (arst_n_i),
    .trig_wr_i     (trig_wr_i),
    .retire_i      (retire_i),
    .hit_o         (etrig_hit)
  );

  sl_support_ctrl u_support_ctrl (
    .in_support_if (in_support_if),
    .arst_n_i      (arst_n_i),
    .retire_i      (retire_i),
    .ctrl_i        (ctrl_i),
    .data_bus_i    (data_bus_i),
    .etrig_hit_i   (etrig_hit),
    .flags_o       (flags_o)
  );

  // ------------------------------------------------------------
  // bus side, one monitor and one buffer per bus
  // ------------------------------------------------------------
  sl_obi_phase_monitor #(
    .CNT_W (CNT_W)
  ) u_data_phase (
    .in_support_if (in_support_if),
    .arst_n_i      (arst_n_i),
    .bus_i         (data_bus_i),
    .phase_o       (data_phase_o)
  );

  sl_obi_phase_monitor #(
    .CNT_W (CNT_W)
  ) u_instr_phase (
    .in_support_if (in_support_if),
    .arst_n_i      (arst_n_i),
    .bus_i         (instr_bus_i),
    .phase_o       (instr_phase_o)
  );

  sl_req_attr_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_data_attr (
    .in_support_if (in_support_if),
    .arst_n_i      (arst_n_i),
    .bus_i         (data_bus_i),
    .attr_o        (data_attr_o)
  );

  sl_req_attr_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_instr_attr (
    .in_support_if (in_support_if),
    .arst_n_i      (arst_n_i),
    .bus_i         (instr_bus_i),
    .attr_o        (instr_attr_o)
  );

endmodule

`default_nettype wire

//--- hdl/sl_support_ctrl.sv
`default_nettype none

module sl_support_ctrl (
  input  wire logic                    in_support_if,
  input  wire logic                    arst_n_i,
  input  wire sl_core_pkg::retire_t    retire_i,
  input  wire sl_core_pkg::core_ctrl_t ctrl_i,
  input  wire sl_obi_pkg::obi_bus_t    data_bus_i,
  input  wire logic                    etrig_hit_i,
  output sl_core_pkg::core_flags_t     flags_o
);

  import sl_core_pkg::*;

  // debug code tracking
  typedef enum logic [1:0] {
    DBG_OUT,
    DBG_IN,
    DBG_DRET
  } dbg_state_e;

  logic       trap_taken;
  logic       exc_active_q;
  logic       data_gnt_q;
  logic       req_after_exc_q;
  logic       late_req;
  dbg_state_e dbg_state_q;
  logic       fetch_seen_q;
  logic       rec_dbg_req_q;
  logic [1:0] dbg_req_cnt_q;

  // ------------------------------------------------------------
  // data request after a trap
  // ------------------------------------------------------------
  assign trap_taken = ctrl_i.pc_set
                   && ((ctrl_i.pc_mux == PC_TRAP_EXC) || (ctrl_i.pc_mux == PC_TRAP_DBE));

  // new address phase right after a granted one
  assign late_req = data_bus_i.req && data_gnt_q;

  always_ff @(posedge in_support_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      data_gnt_q      <= 1'b0;
      exc_active_q    <= 1'b0;
      req_after_exc_q <= 1'b0;
    end else begin
      data_gnt_q <= data_bus_i.gnt;
      if (trap_taken) begin
        exc_active_q <= 1'b1;
        if (late_req) begin
          req_after_exc_q <= 1'b1;
        end
      end else if (retire_i.valid) begin
        // the next retire closes the window
        exc_active_q    <= 1'b0;
        req_after_exc_q <= 1'b0;
      end else if (exc_active_q && late_req) begin
        req_after_exc_q <= 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // debug entry
  // ------------------------------------------------------------
  // DBG_DRET holds off the flag for one cycle after a dret
  always_ff @(posedge in_support_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dbg_state_q <= DBG_OUT;
    end else if (dbg_state_q == DBG_DRET) begin
      dbg_state_q <= DBG_OUT;
    end else if (retire_i.valid) begin
      if (retire_i.is_dret && !retire_i.trap) begin
        dbg_state_q <= DBG_DRET;
      end else if (retire_i.dbg_mode) begin
        dbg_state_q <= DBG_IN;
      end else begin
        dbg_state_q <= DBG_OUT;
      end
    end
  end

  // ------------------------------------------------------------
  // startup and debug request
  // ------------------------------------------------------------
  always_ff @(posedge in_support_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fetch_seen_q <= 1'b0;
    end else if (ctrl_i.fetch_enable) begin
      fetch_seen_q <= 1'b1;
    end
  end

  // retire that arrives with the request does not count
  always_ff @(posedge in_support_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rec_dbg_req_q <= 1'b0;
      dbg_req_cnt_q <= 2'd0;
    end else if (ctrl_i.debug_req) begin
      rec_dbg_req_q <= 1'b1;
      dbg_req_cnt_q <= retire_i.valid ? 2'd1 : 2'd2;
    end else if (retire_i.valid && rec_dbg_req_q) begin
      // drop on the last counted retire
      if (dbg_req_cnt_q == 2'd1) begin
        rec_dbg_req_q <= 1'b0;
      end
      dbg_req_cnt_q <= dbg_req_cnt_q - 2'd1;
    end
  end

  assign flags_o.req_after_exception   = req_after_exc_q;
  assign flags_o.first_debug_ins       = retire_i.valid && retire_i.dbg_mode
                                      && (dbg_state_q == DBG_OUT);
  assign flags_o.first_fetch           = ctrl_i.fetch_enable && !fetch_seen_q;
  assign flags_o.recorded_dbg_req      = rec_dbg_req_q;
  assign flags_o.exception_trigger_hit = etrig_hit_i;

endmodule

`default_nettype wire

//--- hdl/sl_trigger_match.sv
`default_nettype none

module sl_trigger_match #(
  parameter int unsigned NUM_TRIGGERS = 4
) (
  input  wire logic                  in_support_if,
  input  wire logic                  arst_n_i,
  input  wire sl_core_pkg::trig_wr_t trig_wr_i,
  input  wire sl_core_pkg::retire_t  retire_i,
  output logic                       hit_o
);

  import sl_core_pkg::*;

  localparam int unsigned TYPE_MSB = 31;
  localparam int unsigned TYPE_LSB = 28;

  logic [NUM_TRIGGERS-1:0][31:0] tdata1_q;
  logic [NUM_TRIGGERS-1:0][31:0] tdata2_q;
  logic [NUM_TRIGGERS-1:0]       hits;

  // ------------------------------------------------------------
  // trigger CSR shadow
  // ------------------------------------------------------------
  // only implemented indices get a slot, so a write with
  // tselect at or above NUM_TRIGGERS matches no slot
  for (genvar t = 0; t < NUM_TRIGGERS; t++) begin : g_trig

    always_ff @(posedge in_support_if or negedge arst_n_i) begin
      if (!arst_n_i) begin
        tdata1_q[t] <= TDATA1_DEFAULT;
        tdata2_q[t] <= '0;
      end else if (trig_wr_i.valid && (trig_wr_i.tselect == 3'(t))) begin
        tdata1_q[t] <= trig_wr_i.tdata1;
        tdata2_q[t] <= trig_wr_i.tdata2;
      end
    end

    // exception trigger match on the retiring instruction
    logic is_etrig;
    logic cause_hit;
    logic mode_hit;

    // type field selects an exception trigger
    assign is_etrig = (tdata1_q[t][TYPE_MSB:TYPE_LSB] == TYPE_ETRIGGER);

    // tdata2 holds one enable bit per exception cause
    assign cause_hit = tdata2_q[t][retire_i.exception_cause];

    // M and U enables checked against the retiring privilege
    assign mode_hit = (retire_i.is_mmode && tdata1_q[t][ET_M_BIT])
                   || (retire_i.is_umode && tdata1_q[t][ET_U_BIT]);

    assign hits[t] = retire_i.valid
                  && retire_i.exception
                  && is_etrig
                  && cause_hit
                  && mode_hit;

  end

  // any trigger firing counts as a hit
  assign hit_o = |hits;

endmodule

`default_nettype wire

//--- hdl/sl_req_attr_fifo.sv
`default_nettype none

module sl_req_attr_fifo #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  wire logic                  in_support_if,
  input  wire logic                  arst_n_i,
  input  wire sl_obi_pkg::obi_bus_t  bus_i,
  output sl_obi_pkg::resp_attr_t     attr_o
);

  import sl_obi_pkg::*;

  localparam int unsigned IDX_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  logic       gntpar_err;
  logic       gntpar_err_q;
  logic       accept;
  logic       push;
  logic       pop;
  logic       empty;
  logic       full;
  logic [IDX_W-1:0] wr_ptr_q;
  logic [IDX_W-1:0] rd_ptr_q;
  logic [IDX_W:0]   count_q;
  resp_attr_t       entry;
  resp_attr_t       mem_q [FIFO_DEPTH];

  // ------------------------------------------------------------
  // grant parity
  // ------------------------------------------------------------
  // gntpar must be the inverse of gnt while req is high
  // an error seen earlier in the same stalled request sticks
  assign gntpar_err = bus_i.req && ((bus_i.gnt == bus_i.gntpar) || gntpar_err_q);

  always_ff @(posedge in_support_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gntpar_err_q <= 1'b0;
    end else if (bus_i.req && !bus_i.gnt) begin
      gntpar_err_q <= gntpar_err;
    end else begin
      gntpar_err_q <= 1'b0;
    end
  end

  // ------------------------------------------------------------
  // request to response ordering buffer
  // ------------------------------------------------------------
  assign accept = bus_i.req && bus_i.gnt;
  assign empty  = (count_q == '0);
  assign full   = (count_q == (IDX_W+1)'(FIFO_DEPTH));
  assign pop    = bus_i.rvalid && !empty;
  assign push   = accept && (!full || pop);

  // attributes captured at the accepting edge
  always_comb begin
    entry               = '0;
    entry.valid         = 1'b1;
    entry.was_store     = bus_i.we;
    entry.had_integrity = bus_i.integrity;
    entry.gntpar_error  = gntpar_err;
  end

  // entry storage, written at the tail on each accept
  always_ff @(posedge in_support_if) begin
    if (push) begin
      mem_q[wr_ptr_q] <= entry;
    end
  end

  always_ff @(posedge in_support_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // head entry shown while its response is on the bus
  always_comb begin
    attr_o = '0;
    if (pop) begin
      attr_o = mem_q[rd_ptr_q];
    end
  end

endmodule

`default_nettype wire

//--- hdl/sl_obi_phase_monitor.sv
`default_nettype none

module sl_obi_phase_monitor #(
  parameter int unsigned CNT_W = 4
) (
  input  wire logic                  in_support_if,
  input  wire logic                  arst_n_i,
  input  wire sl_obi_pkg::obi_bus_t  bus_i,
  output sl_obi_pkg::obi_phase_t     phase_o
);

  import sl_obi_pkg::*;

  localparam logic [CNT_W-1:0] CNT_MAX = {CNT_W{1'b1}};

  phase_state_e     state_q;
  phase_state_e     state_d;
  logic             accept;
  logic [CNT_W-1:0] cnt_q;

  // ------------------------------------------------------------
  // address phase
  // ------------------------------------------------------------
  assign accept = bus_i.req && bus_i.gnt;

  // a request without grant leaves the address phase open
  always_comb begin
    state_d = PH_IDLE;
    if (bus_i.req && !bus_i.gnt) begin
      state_d = PH_ADDR_WAIT;
    end
  end

  always_ff @(posedge in_support_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= PH_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ------------------------------------------------------------
  // outstanding transfers
  // ------------------------------------------------------------
  // accept and response together leave the count unchanged
  always_ff @(posedge in_support_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (accept && !bus_i.rvalid) begin
      // saturate rather than wrap
      if (cnt_q != CNT_MAX) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end else if (bus_i.rvalid && !accept) begin
      if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // continuation flags follow the bus in the same cycle
  assign phase_o.addr_ph_cont  = bus_i.req && (state_q == PH_ADDR_WAIT);
  assign phase_o.resp_ph_cont  = (cnt_q != '0) && !bus_i.rvalid;
  assign phase_o.v_addr_ph_cnt = OBI_CNT_W'(cnt_q);

endmodule

`default_nettype wire

//--- hdl/sl_obi_pkg.sv
`default_nettype none

package sl_obi_pkg;

  // width of the outstanding-transfer count in the phase status
  localparam int unsigned OBI_CNT_W = 4;

  // one cycle of OBI handshake as seen by the observer
  typedef struct packed {
    logic req;
    logic gnt;
    logic gntpar;
    logic rvalid;
    logic we;
    logic integrity;
  } obi_bus_t;

  // ------------------------------------------------------------
  // derived status per bus
  // ------------------------------------------------------------
  typedef struct packed {
    logic                 addr_ph_cont;
    logic                 resp_ph_cont;
    logic [OBI_CNT_W-1:0] v_addr_ph_cnt;
  } obi_phase_t;

  // attributes of the request that a response belongs to
  typedef struct packed {
    logic valid;
    logic was_store;
    logic had_integrity;
    logic gntpar_error;
  } resp_attr_t;

  // address phase tracking
  typedef enum logic {
    PH_IDLE,
    PH_ADDR_WAIT
  } phase_state_e;

endpackage

`default_nettype wire

//--- hdl/sl_core_pkg.sv
`default_nettype none

package sl_core_pkg;

  // ------------------------------------------------------------
  // PC mux sources as driven by the core controller
  // ------------------------------------------------------------
  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_BRANCH,
    PC_TRAP_EXC,
    PC_TRAP_DBE,
    PC_DRET
  } pc_mux_e;

  // retire port, reduced to what the flags need
  typedef struct packed {
    logic       valid;
    logic       dbg_mode;
    logic       is_dret;
    logic       trap;
    logic       exception;
    logic [4:0] exception_cause;
    logic       is_mmode;
    logic       is_umode;
  } retire_t;

  // controller events sampled every cycle
  typedef struct packed {
    logic    pc_set;
    pc_mux_e pc_mux;
    logic    fetch_enable;
    logic    debug_req;
  } core_ctrl_t;

  // trigger CSR write from the core's CSR stage
  typedef struct packed {
    logic        valid;
    logic [2:0]  tselect;
    logic [31:0] tdata1;
    logic [31:0] tdata2;
  } trig_wr_t;

  // derived flags for the property checks
  typedef struct packed {
    logic req_after_exception;
    logic first_debug_ins;
    logic first_fetch;
    logic recorded_dbg_req;
    logic exception_trigger_hit;
  } core_flags_t;

  // ------------------------------------------------------------
  // trigger field constants
  // ------------------------------------------------------------
  // type 15 in the top nibble, trigger disabled
  localparam logic [31:0] TDATA1_DEFAULT = 32'hF800_0000;
  localparam logic [3:0]  TYPE_ETRIGGER  = 4'd5;
  localparam int unsigned ET_M_BIT       = 9;
  localparam int unsigned ET_U_BIT       = 6;

endpackage

`default_nettype wire
